// ==== sim.f ====
+incdir+testbench
src/issue_pkg.sv
src/dispatch_stage.sv
src/rs_entry.sv
src/rs_station.sv
src/exec_stage.sv
src/issue_core.sv
testbench/issue_core_tb.sv

// ==== Bender.yml ====
package:
  name: issue_core

sources:
  # Design, package first
  - files:
      - src/issue_pkg.sv
      - src/dispatch_stage.sv
      - src/rs_entry.sv
      - src/rs_station.sv
      - src/exec_stage.sv
      - src/issue_core.sv

  # Testbench with its included vector table
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/issue_core_tb.sv

// ==== testbench/issue_core_vectors.svh ====
// Instruction table for the issue slice testbench
// Operand values are random words drawn when a row is dispatched
// A waiting operand names the dest tag of an earlier row still in flight
// Dest tags are unique over the whole run and tag 63 is never produced
`ifndef ISSUE_CORE_VECTORS_SVH
`define ISSUE_CORE_VECTORS_SVH

// Columns: name, op, opa waits, opa tag, opb waits, opb tag, dest, rob_idx
// Expected results are worked out at dispatch from the op rule
typedef struct {
	string    name;
	op_t      op;
	logic     a_wait;			// opa sent as a tag
	tag_t     a_tag;
	logic     b_wait;			// opb sent as a tag
	tag_t     b_tag;
	tag_t     dest;
	rob_idx_t rob_idx;
} vec_t;

localparam int NUM_VECS = 19;

vec_t vectors [NUM_VECS] = '{
	// Independent adder unit ops
	'{"add_ind",       OP_ADD, 1'b0, 6'd0,  1'b0, 6'd0,  6'd1,  5'd1},
	'{"sub_ind",       OP_SUB, 1'b0, 6'd0,  1'b0, 6'd0,  6'd2,  5'd2},
	'{"and_ind",       OP_AND, 1'b0, 6'd0,  1'b0, 6'd0,  6'd3,  5'd3},
	'{"or_ind",        OP_OR,  1'b0, 6'd0,  1'b0, 6'd0,  6'd4,  5'd4},
	'{"xor_ind",       OP_XOR, 1'b0, 6'd0,  1'b0, 6'd0,  6'd5,  5'd5},
	// Chains woken from cdb1 then cdb2
	'{"add_src",       OP_ADD, 1'b0, 6'd0,  1'b0, 6'd0,  6'd6,  5'd6},
	'{"sub_dep_cdb1",  OP_SUB, 1'b1, 6'd6,  1'b0, 6'd0,  6'd7,  5'd7},
	'{"xor_dep_chain", OP_XOR, 1'b1, 6'd7,  1'b0, 6'd0,  6'd8,  5'd8},
	'{"mul_src",       OP_MUL, 1'b0, 6'd0,  1'b0, 6'd0,  6'd9,  5'd9},
	'{"add_dep_cdb2",  OP_ADD, 1'b1, 6'd9,  1'b0, 6'd0,  6'd10, 5'd10},
	// Back to back multiplies and mixed dependents
	'{"mul_b2b_0",     OP_MUL, 1'b0, 6'd0,  1'b0, 6'd0,  6'd11, 5'd11},
	'{"mul_b2b_1",     OP_MUL, 1'b0, 6'd0,  1'b0, 6'd0,  6'd12, 5'd12},
	'{"mul_b2b_2",     OP_MUL, 1'b0, 6'd0,  1'b0, 6'd0,  6'd13, 5'd13},
	'{"add_two_mul",   OP_ADD, 1'b1, 6'd11, 1'b1, 6'd12, 6'd14, 5'd14},
	'{"add_dep_mul",   OP_ADD, 1'b1, 6'd13, 1'b0, 6'd0,  6'd15, 5'd15},
	'{"xor_add_mul",   OP_XOR, 1'b1, 6'd15, 1'b1, 6'd12, 6'd16, 5'd20},
	'{"mul_dep_add",   OP_MUL, 1'b1, 6'd14, 1'b1, 6'd16, 6'd17, 5'd25},
	'{"sub_wrap",      OP_SUB, 1'b0, 6'd0,  1'b0, 6'd0,  6'd18, 5'd30},
	'{"and_late",      OP_AND, 1'b0, 6'd0,  1'b0, 6'd0,  6'd19, 5'd31}
};

`endif

// ==== testbench/issue_core_tb.sv ====
// Testbench for issue_core driven by the rows in issue_core_vectors.svh
// Results are scored by dest tag on cdb1 and cdb2, never by cycle
// A dependent row must reach the station before its producer broadcasts
// Inputs change and outputs are sampled on the falling edge
module issue_core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import issue_pkg::*;

	localparam int   RS_DEPTH    = 8;
	localparam int   MULT_CYCLES = 4;
	localparam int   CLOCK_NS    = 20;
	localparam tag_t NEVER_TAG   = 6'd63;	// No row produces it

	`include "issue_core_vectors.svh"

	localparam int WATCHDOG_NS = NUM_VECS * (MULT_CYCLES + 10) * CLOCK_NS;

	logic          clock;
	logic          reset;
	dispatch_pkt_t dispatch_in;
	logic          rs_full;
	cdb_t          cdb1;
	cdb_t          cdb2;

	// Scoreboard indexed by dest tag
	word_t    exp_value   [PRF_SIZE];
	rob_idx_t exp_rob     [PRF_SIZE];
	logic     exp_on_mult [PRF_SIZE];	// Result due on cdb2
	string    exp_name    [PRF_SIZE];
	logic     pending     [PRF_SIZE];	// Dispatched and not yet seen
	int       done_count = 0;

	issue_core #(.RS_DEPTH(RS_DEPTH), .MULT_CYCLES(MULT_CYCLES)) i_issue_core (
		.clock       (clock),
		.reset       (reset),
		.dispatch_in (dispatch_in),
		.rs_full     (rs_full),
		.cdb1        (cdb1),
		.cdb2        (cdb2)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_NS / 2) clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Reporting and compares
	//////////////////////////////////////////////////
	task automatic stop_run(string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(string name, word_t expected, word_t actual);
		if (actual !== expected)
			stop_run($sformatf("MISMATCH %s expected %h actual %h",
				name, expected, actual));
	endtask

	task automatic check_rob(string name, rob_idx_t expected, rob_idx_t actual);
		if (actual !== expected)
			stop_run($sformatf("MISMATCH %s expected %0d actual %0d",
				name, expected, actual));
	endtask

	task automatic check_level(string name, logic expected, logic actual);
		if (actual !== expected)
			stop_run($sformatf("MISMATCH %s expected %b actual %b",
				name, expected, actual));
	endtask

	// No result in flight and nothing on the buses
	task automatic expect_idle(string name);
		check_level({name, "_rs_full"}, 1'b0, rs_full);
		check_level({name, "_cdb1_valid"}, 1'b0, cdb1.valid);
		check_level({name, "_cdb2_valid"}, 1'b0, cdb2.valid);
	endtask

	//////////////////////////////////////////////////
	// Stimulus and expected values
	//////////////////////////////////////////////////
	function automatic word_t random_word();
		return {$urandom, $urandom};
	endfunction

	// Result rule per op modulo 2^64
	function automatic word_t op_result(op_t op, word_t a, word_t b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			default: return a * b;		// Low half of the product
		endcase
	endfunction

	function automatic dispatch_pkt_t make_pkt(vec_t v);
		dispatch_pkt_t pkt;
		pkt.valid     = 1'b1;
		pkt.op        = v.op;
		pkt.opa.value = random_word();
		pkt.opa_valid = !v.a_wait;
		if (v.a_wait)
			pkt.opa.tag_view.tag = v.a_tag;	// Pad bits stay random
		pkt.opb.value = random_word();
		pkt.opb_valid = !v.b_wait;
		if (v.b_wait)
			pkt.opb.tag_view.tag = v.b_tag;
		pkt.dest      = v.dest;
		pkt.rob_idx   = v.rob_idx;
		return pkt;
	endfunction

	// Operand waits on a tag that is never broadcast
	function automatic dispatch_pkt_t blocked_pkt(int i);
		dispatch_pkt_t pkt;
		pkt.valid            = 1'b1;
		pkt.op               = OP_ADD;
		pkt.opa.value        = random_word();
		pkt.opa.tag_view.tag = NEVER_TAG;
		pkt.opa_valid        = 1'b0;
		pkt.opb.value        = random_word();
		pkt.opb_valid        = 1'b1;
		pkt.dest             = tag_t'(40 + i);
		pkt.rob_idx          = rob_idx_t'(i);
		return pkt;
	endfunction

	task automatic record_expected(vec_t v, dispatch_pkt_t pkt);
		word_t a;
		word_t b;
		a = v.a_wait ? exp_value[v.a_tag] : pkt.opa.value;	// Producer result
		b = v.b_wait ? exp_value[v.b_tag] : pkt.opb.value;
		exp_value[v.dest]   = op_result(v.op, a, b);
		exp_rob[v.dest]     = v.rob_idx;
		exp_on_mult[v.dest] = (v.op == OP_MUL);
		exp_name[v.dest]    = v.name;
		pending[v.dest]     = 1'b1;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) @(negedge clock);
		reset = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Result monitor
	//////////////////////////////////////////////////
	task automatic score_broadcast(cdb_t bus, logic on_mult);
		if (!pending[bus.tag])
			stop_run($sformatf("Tag %0d broadcast while not in flight or twice", bus.tag));
		else
		begin
			check_level({exp_name[bus.tag], "_on_cdb2"}, exp_on_mult[bus.tag], on_mult);
			check_word(exp_name[bus.tag], exp_value[bus.tag], bus.value);
			check_rob({exp_name[bus.tag], "_rob"}, exp_rob[bus.tag], bus.rob_idx);
			pending[bus.tag] = 1'b0;
			done_count++;
		end
	endtask

	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (cdb1.valid === 1'b1)
				score_broadcast(cdb1, 1'b0);
			if (cdb2.valid === 1'b1)
				score_broadcast(cdb2, 1'b1);
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		stop_run($sformatf("Watchdog expired, results never arrived (%0d of %0d seen)",
			done_count, NUM_VECS));
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial
	begin
		dispatch_pkt_t pkt;
		void'($urandom(32'h5acb0c89));		// Seeded once
		reset       = 1'b1;
		dispatch_in = '0;
		for (int t = 0; t < PRF_SIZE; t++)
			pending[t] = 1'b0;
		apply_reset();

		repeat (5)				// Quiet until something is sent
		begin
			@(negedge clock);
			expect_idle("after_reset");
		end

		for (int i = 0; i < NUM_VECS; i++)
		begin
			@(negedge clock);
			while (rs_full)			// Hold off the strobe
			begin
				dispatch_in.valid = 1'b0;
				@(negedge clock);
			end
			pkt = make_pkt(vectors[i]);
			record_expected(vectors[i], pkt);
			dispatch_in = pkt;
		end
		@(negedge clock);
		dispatch_in.valid = 1'b0;
		while (done_count < NUM_VECS)		// Watchdog bounds this
			@(negedge clock);

		// Fill the station with entries that never wake
		for (int i = 0; i < RS_DEPTH; i++)
		begin
			@(negedge clock);
			check_level("fill_not_full", 1'b0, rs_full);
			dispatch_in = blocked_pkt(i);
		end
		@(negedge clock);
		dispatch_in.valid = 1'b0;
		repeat (3)
		begin
			check_level("fill_full", 1'b1, rs_full);
			@(negedge clock);
		end
		apply_reset();				// Only way out of a stuck station
		@(negedge clock);
		expect_idle("after_second_reset");

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== src/issue_core.sv ====
// Issue slice top level, dispatch then station then execute
// cdb1 and cdb2 feed back into the station and are also the results
// Do not strobe dispatch_in while rs_full is high
// RS_DEPTH and MULT_CYCLES are passed down to the stages
module issue_core #(
	parameter int RS_DEPTH    = 8,
	parameter int MULT_CYCLES = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	input  issue_pkg::dispatch_pkt_t dispatch_in,
	output logic                     rs_full,
	output issue_pkg::cdb_t          cdb1,		// Adder results
	output issue_pkg::cdb_t          cdb2		// Multiplier results
);
	import issue_pkg::*;

	rs_pkt_t    rs_in;				// Decoded instruction
	issue_pkt_t issue;				// Station to execute
	logic       mult_available;

	dispatch_stage i_dispatch_stage (
		.clock       (clock),
		.reset       (reset),
		.dispatch_in (dispatch_in),
		.rs_in       (rs_in)
	);

	rs_station #(.RS_DEPTH(RS_DEPTH)) i_rs_station (
		.clock          (clock),
		.reset          (reset),
		.rs_in          (rs_in),
		.cdb1           (cdb1),		// Wakeup path
		.cdb2           (cdb2),
		.mult_available (mult_available),
		.rs_full        (rs_full),
		.issue          (issue)
	);

	exec_stage #(.MULT_CYCLES(MULT_CYCLES)) i_exec_stage (
		.clock          (clock),
		.reset          (reset),
		.issue          (issue),
		.cdb1           (cdb1),
		.cdb2           (cdb2),
		.mult_available (mult_available)
	);

endmodule

// ==== src/exec_stage.sv ====
// Execute stage with a single-cycle adder unit and an iterative multiplier
// Adder result appears on cdb1 one cycle after issue
// Multiplier result appears on cdb2 MULT_CYCLES cycles after issue
// MULT_CYCLES must be a power of two from 2 to 64, it splits opb in chunks
// Only the low 64 bits of the product are kept
module exec_stage #(
	parameter int MULT_CYCLES = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  issue_pkg::issue_pkt_t issue,
	output issue_pkg::cdb_t       cdb1,		// Adder unit results
	output issue_pkg::cdb_t       cdb2,		// Multiplier results
	output logic                  mult_available
);
	import issue_pkg::*;

	localparam int CHUNK = WORD_W / MULT_CYCLES;	// opb bits per step
	localparam int CNT_W = $clog2(MULT_CYCLES + 1);

	word_t            alu_result;
	logic             adder_go;
	logic             mult_go;
	logic             busy;				// Multiply in progress
	logic [CNT_W-1:0] count;			// Steps left
	word_t            mcand;			// Shifted multiplicand
	word_t            mplier;			// Remaining multiplier bits
	word_t            acc;				// Partial product sum
	word_t            step_sum;

	assign adder_go       = issue.valid && (issue.fu_select == USE_ADDER);
	assign mult_go        = issue.valid && (issue.fu_select == USE_MULTIPLIER);
	assign mult_available = !busy && !mult_go;	// Low from the issue cycle on

	//////////////////////////////////////////////////
	// Adder unit
	//////////////////////////////////////////////////
	always_comb
	begin
		case (issue.alu_func)
			ALU_ADD: alu_result = issue.opa + issue.opb;	// Wraps mod 2^64
			ALU_SUB: alu_result = issue.opa - issue.opb;
			ALU_AND: alu_result = issue.opa & issue.opb;
			ALU_OR:  alu_result = issue.opa | issue.opb;
			ALU_XOR: alu_result = issue.opa ^ issue.opb;
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			cdb1.valid <= 1'b0;
		else
		begin
			cdb1.valid <= adder_go;
			if (adder_go)
			begin
				cdb1.tag     <= issue.dest;
				cdb1.value   <= alu_result;
				cdb1.rob_idx <= issue.rob_idx;
			end
		end
	end

	//////////////////////////////////////////////////
	// Multiplier, one CHUNK of opb per cycle
	//////////////////////////////////////////////////
	assign step_sum = acc + mcand * word_t'(mplier[CHUNK-1:0]);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy       <= 1'b0;
			cdb2.valid <= 1'b0;
		end
		else
		begin
			cdb2.valid <= 1'b0;			// Single cycle pulse
			if (mult_go)
			begin
				busy         <= 1'b1;
				count        <= CNT_W'(MULT_CYCLES - 1);
				acc          <= issue.opa * word_t'(issue.opb[CHUNK-1:0]);	// First chunk
				mcand        <= issue.opa << CHUNK;
				mplier       <= issue.opb >> CHUNK;
				cdb2.tag     <= issue.dest;
				cdb2.rob_idx <= issue.rob_idx;
			end
			else if (busy)
			begin
				if (count == CNT_W'(1))
				begin
					busy       <= 1'b0;
					cdb2.valid <= 1'b1;
					cdb2.value <= step_sum;	// Last chunk folded in
				end
				else
				begin
					count  <= count - 1'b1;
					acc    <= step_sum;
					mcand  <= mcand << CHUNK;
					mplier <= mplier >> CHUNK;
				end
			end
		end
	end

	// Station must wait out a running multiply
	a_mult_not_busy: assert property (@(posedge clock) disable iff (reset)
		mult_go |-> !busy)
		else $error("multiply issued while multiplier busy");

endmodule

// ==== src/rs_station.sv ====
// Reservation station with RS_DEPTH entries
// Loads the lowest free entry and issues the lowest ready entry in each cycle
// rs_full already counts an instruction sitting in the dispatch register,
// so one strobe accepted while rs_full was low always finds an entry
// The adder is always available. Multiplier availability is registered,
// and cleared locally on a multiply issue so two can never go back to back
module rs_station #(
	parameter int RS_DEPTH = 8
) (
	input  logic                  clock,
	input  logic                  reset,
	input  issue_pkg::rs_pkt_t    rs_in,		// From dispatch
	input  issue_pkg::cdb_t       cdb1,
	input  issue_pkg::cdb_t       cdb2,
	input  logic                  mult_available,	// From execute
	output logic                  rs_full,
	output issue_pkg::issue_pkt_t issue		// Registered issue packet
);
	import issue_pkg::*;

	logic [RS_DEPTH-1:0] load;			// One-hot load select
	logic [RS_DEPTH-1:0] free;
	logic [RS_DEPTH-1:0] ready;
	logic [RS_DEPTH-1:0] fu_ready;
	logic [RS_DEPTH-1:0] use_enable;		// One-hot issue grant
	issue_pkt_t          entry_out [RS_DEPTH];
	issue_pkt_t          pick;			// Granted entry contents
	logic                mult_avail_q;		// Sampled a cycle earlier
	logic                issue_mult;		// Multiply granted this cycle

	// Keep only the lowest set bit
	function automatic logic [RS_DEPTH-1:0] lowest_one(logic [RS_DEPTH-1:0] req);
		return req & (~req + 1'b1);
	endfunction

	//////////////////////////////////////////////////
	// Entries
	//////////////////////////////////////////////////
	for (genvar g = 0; g < RS_DEPTH; g++)
	begin : g_entry
		assign fu_ready[g] = (entry_out[g].fu_select == USE_MULTIPLIER) ?
			mult_avail_q : 1'b1;		// Adder never busy

		rs_entry i_rs_entry (
			.clock      (clock),
			.reset      (reset),
			.load       (load[g]),
			.entry_in   (rs_in),
			.cdb1       (cdb1),
			.cdb2       (cdb2),
			.fu_ready   (fu_ready[g]),
			.use_enable (use_enable[g]),
			.ready      (ready[g]),
			.free       (free[g]),
			.entry_out  (entry_out[g])
		);
	end

	//////////////////////////////////////////////////
	// Allocate and select
	//////////////////////////////////////////////////
	assign load       = rs_in.valid ? lowest_one(free) : '0;
	assign rs_full    = ~|free || (rs_in.valid && ~|(free & (free - 1'b1)));	// 0 or 1 left
	assign use_enable = lowest_one(ready);

	always_comb
	begin
		pick = '0;
		for (int i = 0; i < RS_DEPTH; i++)
			if (use_enable[i])
				pick = entry_out[i];		// Grant is one-hot, valid is in-use
	end

	assign issue_mult = |use_enable && (pick.fu_select == USE_MULTIPLIER);

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			issue.valid  <= 1'b0;
			mult_avail_q <= 1'b0;		// Picks up the real level next cycle
		end
		else
		begin
			issue        <= pick;
			mult_avail_q <= mult_available && !issue_mult;
		end
	end

	// rs_full is honoured upstream, so a load always finds a free entry
	a_no_load_when_full: assert property (@(posedge clock) disable iff (reset)
		rs_in.valid |-> |free)
		else $error("load into a full station");

	// The registered sample must never grant into a running multiply
	a_mult_grant_idle: assert property (@(posedge clock) disable iff (reset)
		issue_mult |-> mult_available)
		else $error("multiply granted while multiplier not available");

endmodule

// ==== src/rs_entry.sv ====
// One reservation station entry
// The station loads an entry only while it is free
// Operands wake from cdb1 and cdb2 at the clock edge after the broadcast
// A result broadcast in the load cycle is captured during the load
// Tags must be unique in flight, so both buses never match one operand
module rs_entry (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 load,		// Take entry_in at this edge
	input  issue_pkg::rs_pkt_t   entry_in,
	input  issue_pkg::cdb_t      cdb1,		// Adder results
	input  issue_pkg::cdb_t      cdb2,		// Multiplier results
	input  logic                 fu_ready,	// Registered unit availability
	input  logic                 use_enable,	// Issued this cycle and frees the entry
	output logic                 ready,
	output logic                 free,
	output issue_pkg::issue_pkt_t entry_out
);
	import issue_pkg::*;

	rs_pkt_t held;					// valid doubles as in-use
	rs_pkt_t base;					// Load source or held copy
	rs_pkt_t nxt;					// After wakeup
	logic    a_hit1;				// Operand A matches cdb1
	logic    a_hit2;				// Operand A matches cdb2
	logic    b_hit1;
	logic    b_hit2;

	// Waiting operand whose tag is on the bus
	function automatic logic hits(cdb_t bus, operand_u op, logic op_valid);
		return bus.valid && !op_valid && (bus.tag == op.tag_view.tag);
	endfunction

	//////////////////////////////////////////////////
	// Wakeup
	//////////////////////////////////////////////////
	always_comb
	begin
		base   = load ? entry_in : held;
		a_hit1 = hits(cdb1, base.opa, base.opa_valid);
		a_hit2 = hits(cdb2, base.opa, base.opa_valid);
		b_hit1 = hits(cdb1, base.opb, base.opb_valid);
		b_hit2 = hits(cdb2, base.opb, base.opb_valid);

		nxt       = base;
		nxt.valid = load || (held.valid && !use_enable);	// Issue frees it
		if (a_hit1 || a_hit2)
		begin
			nxt.opa.value = a_hit2 ? cdb2.value : cdb1.value;	// cdb2 wins
			nxt.opa_valid = 1'b1;
		end
		if (b_hit1 || b_hit2)
		begin
			nxt.opb.value = b_hit2 ? cdb2.value : cdb1.value;
			nxt.opb_valid = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Entry state
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			held.valid     <= 1'b0;
			held.opa_valid <= 1'b0;
			held.opb_valid <= 1'b0;
		end
		else if (load || held.valid)
			held <= nxt;			// Idle entries stay quiet
	end

	// Flags out to the station
	assign free  = !held.valid;
	assign ready = held.valid && held.opa_valid && held.opb_valid && fu_ready;

	// Held fields as an issue packet
	assign entry_out.valid     = held.valid;
	assign entry_out.fu_select = held.fu_select;
	assign entry_out.alu_func  = held.alu_func;
	assign entry_out.opa       = held.opa.value;	// Only read once valid
	assign entry_out.opb       = held.opb.value;
	assign entry_out.dest      = held.dest;
	assign entry_out.rob_idx   = held.rob_idx;

	// Unique tags let at most one bus wake an operand
	a_one_bus_match: assert property (@(posedge clock) disable iff (reset)
		!(a_hit1 && a_hit2) && !(b_hit1 && b_hit2))
		else $error("both result buses match one waiting operand");

endmodule

// ==== src/dispatch_stage.sv ====
// Dispatch register and decode, one instruction per strobe
// rs_in is valid exactly one cycle after a strobe on dispatch_in
// The sender must hold the strobe off while rs_full is high
// Illegal op codes decode to the adder unit with ALU_DEFAULT
module dispatch_stage (
	input  logic                    clock,
	input  logic                    reset,
	input  issue_pkg::dispatch_pkt_t dispatch_in,	// From rename side
	output issue_pkg::rs_pkt_t      rs_in		// To the station
);
	import issue_pkg::*;

	rs_pkt_t decoded;				// Next contents of rs_in

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	always_comb
	begin
		decoded.valid     = dispatch_in.valid;
		decoded.fu_select = USE_ADDER;		// Most ops go to the adder unit
		decoded.alu_func  = ALU_DEFAULT;
		case (dispatch_in.op)
			OP_ADD: decoded.alu_func = ALU_ADD;
			OP_SUB: decoded.alu_func = ALU_SUB;
			OP_AND: decoded.alu_func = ALU_AND;
			OP_OR:  decoded.alu_func = ALU_OR;
			OP_XOR: decoded.alu_func = ALU_XOR;
			OP_MUL: decoded.fu_select = USE_MULTIPLIER;	// ALU stays idle
			default: decoded.alu_func = ALU_DEFAULT;
		endcase
		decoded.opa       = dispatch_in.opa;	// Tag or value, passed as is
		decoded.opa_valid = dispatch_in.opa_valid;
		decoded.opb       = dispatch_in.opb;
		decoded.opb_valid = dispatch_in.opb_valid;
		decoded.dest      = dispatch_in.dest;
		decoded.rob_idx   = dispatch_in.rob_idx;
	end

	//////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
			rs_in.valid <= 1'b0;
		else if (dispatch_in.valid)
			rs_in <= decoded;			// Payload only moves on a strobe
		else
			rs_in.valid <= 1'b0;
	end

	// The rename side sends only the six defined op codes
	a_known_op: assert property (@(posedge clock) disable iff (reset)
		dispatch_in.valid |-> dispatch_in.op inside {OP_ADD, OP_SUB, OP_AND,
			OP_OR, OP_XOR, OP_MUL})
		else $error("dispatch of unknown op code %0d", dispatch_in.op);

endmodule

// ==== src/issue_pkg.sv ====
// Shared types for the issue slice
// Tags come from the stimulus. There is no rename table or ROB here
// An operand word is a tag until its valid flag is set, then a value
// Only the low TAG_W bits of an operand take part in tag compares
package issue_pkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////
	localparam int WORD_W   = 64;			// Datapath width
	localparam int PRF_SIZE = 64;			// Physical registers
	localparam int ROB_SIZE = 32;			// ROB entries
	localparam int TAG_W    = $clog2(PRF_SIZE);	// 6 bit tags
	localparam int ROB_W    = $clog2(ROB_SIZE);	// 5 bit ROB index

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [ROB_W-1:0]  rob_idx_t;

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_MUL = 3'd5
	} op_t;						// Codes 6 and 7 are illegal

	typedef enum logic {
		USE_ADDER      = 1'b0,
		USE_MULTIPLIER = 1'b1
	} fu_select_t;

	typedef enum logic [2:0] {
		ALU_ADD     = 3'd0,
		ALU_SUB     = 3'd1,
		ALU_AND     = 3'd2,
		ALU_OR      = 3'd3,
		ALU_XOR     = 3'd4,
		ALU_DEFAULT = 3'd7			// Idle, adder unit returns zero
	} alu_func_t;

	// One operand word read as a value or as a waiting tag
	typedef union packed {
		word_t value;				// Once the valid flag is set
		struct packed {
			logic [WORD_W-TAG_W-1:0] pad;	// Ignored while waiting
			tag_t                    tag;	// Producer tag
		} tag_view;
	} operand_u;

	//////////////////////////////////////////////////
	// Stage packets
	//////////////////////////////////////////////////
	typedef struct packed {
		logic     valid;			// One cycle strobe
		op_t      op;
		operand_u opa;
		logic     opa_valid;
		operand_u opb;
		logic     opb_valid;
		tag_t     dest;
		rob_idx_t rob_idx;
	} dispatch_pkt_t;

	typedef struct packed {
		logic       valid;
		fu_select_t fu_select;
		alu_func_t  alu_func;
		operand_u   opa;
		logic       opa_valid;
		operand_u   opb;
		logic       opb_valid;
		tag_t       dest;
		rob_idx_t   rob_idx;
	} rs_pkt_t;

	typedef struct packed {
		logic       valid;			// One cycle pulse
		fu_select_t fu_select;
		alu_func_t  alu_func;
		word_t      opa;
		word_t      opb;
		tag_t       dest;
		rob_idx_t   rob_idx;
	} issue_pkt_t;

	typedef struct packed {
		logic     valid;			// One cycle pulse per tag
		tag_t     tag;
		word_t    value;
		rob_idx_t rob_idx;
	} cdb_t;

endpackage
